// File: Bender.yml
package:
  name: psum_path

sources:
  - verilog/psum_pkg.sv
  - verilog/psum_glb.sv
  - verilog/psum_ctrl.sv
  - verilog/ipsum_buffer.sv
  - verilog/psum_reducer.sv
  - verilog/psum_top.sv
  - target: test
    files:
      - tb/psum_props.sv
      - tb/tb_psum_top.sv

// File: tb/psum_props.sv
`timescale 1ns/1ps
`default_nettype none

module psum_props (
    input logic clk,
    input logic reset,
    input logic ready_ip,
    input logic ipsum_out_f,
    input logic glb_rd_valid,
    input logic busy,
    input logic done
);

    // load and drain phases never overlap
    no_overlap: assert property (@(posedge clk) disable iff (reset)
        !(ready_ip && ipsum_out_f))
        else $error("ready_ip and ipsum_out_f high in the same cycle");

    drain_len: assert property (@(posedge clk) disable iff (reset)
        $rose(ipsum_out_f) |-> ipsum_out_f [*4] ##1 !ipsum_out_f)
        else $error("ipsum_out_f did not last exactly four cycles");

    done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |-> !busy ##1 !done)
        else $error("done longer than one cycle or busy still high");

    // read data may only arrive while the buffer accepts it
    valid_in_load: assert property (@(posedge clk) disable iff (reset)
        glb_rd_valid |-> ready_ip)
        else $error("glb_rd_valid seen with ready_ip low");

endmodule

bind psum_ctrl psum_props props0 (
    .clk          (clk),
    .reset        (reset),
    .ready_ip     (ready_ip),
    .ipsum_out_f  (ipsum_out_f),
    .glb_rd_valid (glb_rd_valid),
    .busy         (busy),
    .done         (done)
);

`default_nettype wire

// File: tb/tb_psum_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_psum_top import psum_pkg::*; ();

    localparam int ROW_NUM = 32;
    localparam int TIMEOUT = 200; // cycles from start to first beat

    logic                clk;
    logic                reset;
    logic                wr_en;
    glb_addr_t           wr_addr;
    glb_word_t           wr_data;
    logic                start;
    layer_mode_t         layer_mode;
    row_cnt_t            row_en;
    glb_addr_t           base_addr;
    psum_t [ROW_NUM-1:0] pe_psum;
    psum_t [ROW_NUM-1:0] opsum;
    logic                opsum_valid;
    logic                busy;
    logic                done;
    glb_word_t           glb_img [64]; // host copy of the glb contents
    logic [15:0]         lfsr;
    int                  err_cnt;

    psum_top #(.ROW_NUM(ROW_NUM)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // stimulus and model

    // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic psum_t sat_add(input psum_t a, input psum_t b);
        int s;
        s = int'(a) + int'(b);
        return (s > 32767) ? PSUM_MAX : (s < -32768) ? PSUM_MIN : psum_t'(s);
    endfunction

    // what row r presents at drain beat k
    function automatic psum_t ipsum_at(input layer_mode_t mode, input int rows,
                                       input glb_addr_t base, input int r, input int k);
        glb_word_t w;
        if (r >= rows) begin
            return '0; // cleared at start
        end
        if (mode == LAYER_PW) begin
            w = glb_img[glb_addr_t'(base + 2 * r + k / 2)];
        end else if (r % 3 == 0 && k < 2) begin
            w = glb_img[glb_addr_t'(base + r / 3)];
        end else begin
            return '0;
        end
        return (k % 2 == 1) ? w[31:16] : w[15:0];
    endfunction

    // --------------------
    // one pass with fresh glb words and pe psums

    task automatic run_pass(input layer_mode_t mode, input int rows, input glb_addr_t base,
                            input logic near_lim, input logic extra_start);
        logic [31:0] v;
        glb_addr_t   a;
        int          words;
        int          wait_cnt;
        psum_t       exp_val;
        words = (mode == LAYER_DW) ? (rows + 2) / 3 : 2 * rows;
        for (int i = 0; i < words; i++) begin
            v = rand_bits(32);
            if (near_lim) begin // even rows 24k and up, odd rows -20k and down
                v[31:28] = (i % 4 < 2) ? 4'h6 : 4'ha;
                v[15:12] = v[31:28];
            end
            a = glb_addr_t'(base + i);
            @(posedge clk);
            wr_en      <= 1'b1;
            wr_addr    <= a;
            wr_data    <= v;
            glb_img[a] = v;
        end
        @(posedge clk);
        wr_en <= 1'b0;
        for (int r = 0; r < ROW_NUM; r++) begin
            v = rand_bits(16);
            pe_psum[r] <= near_lim ? ((r % 2 == 0) ? 16'h7000 : 16'h9000) : v[15:0];
        end
        start      <= 1'b1;
        layer_mode <= mode;
        row_en     <= row_cnt_t'(rows);
        base_addr  <= base;
        @(posedge clk);
        start <= 1'b0;
        if (extra_start) begin // lands while busy
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        wait_cnt = 0;
        @(negedge clk);
        while (opsum_valid !== 1'b1 && wait_cnt < TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (opsum_valid !== 1'b1) begin
            err_cnt++;
            $display("timeout, no opsum_valid within %0d cycles of start", TIMEOUT);
            return;
        end
        for (int k = 0; k < 4; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            if (opsum_valid !== 1'b1) begin
                err_cnt++;
                $display("ERR opsum_valid beat %0d: expected 1, actual %h", k, opsum_valid);
            end
            if (done !== (k == 3)) begin
                err_cnt++;
                $display("ERR done beat %0d: expected %h, actual %h", k, k == 3, done);
            end
            if (busy !== (k != 3)) begin // busy falls with the last beat
                err_cnt++;
                $display("ERR busy beat %0d: expected %h, actual %h", k, k != 3, busy);
            end
            for (int r = 0; r < ROW_NUM; r++) begin
                exp_val = sat_add(ipsum_at(mode, rows, base, r, k), pe_psum[r]);
                if (opsum[r] !== exp_val) begin
                    err_cnt++;
                    $display("ERR opsum lane %0d beat %0d: expected %h, actual %h",
                             r, k, exp_val, opsum[r]);
                end
            end
        end
        @(negedge clk);
        if (opsum_valid !== 1'b0) begin
            err_cnt++;
            $display("ERR opsum_valid after last beat: expected 0, actual %h", opsum_valid);
        end
    endtask

    // --------------------
    // test sequence

    initial begin
        reset      = 1'b1;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        start      = 1'b0;
        layer_mode = LAYER_PW;
        row_en     = '0;
        base_addr  = '0;
        pe_psum    = '0;
        lfsr       = 16'd87;
        err_cnt    = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (opsum !== '0 || busy !== 1'b0 || done !== 1'b0) begin
            err_cnt++;
            $display("ERR opsum/busy/done after reset: expected 0 0 0, actual %h %h %h",
                     opsum, busy, done);
        end

        run_pass(LAYER_PW, 32, 6'd0, 1'b0, 1'b0);
        run_pass(LAYER_PW, 5, 6'd16, 1'b0, 1'b0);  // rows 5 and up drain zeros
        run_pass(LAYER_DW, 32, 6'd40, 1'b0, 1'b0);
        run_pass(LAYER_PW, 32, 6'd0, 1'b1, 1'b0);  // clamps at both limits

        // second start during a pass, then a start with no rows
        run_pass(LAYER_PW, 2, 6'd0, 1'b0, 1'b1);
        @(posedge clk);
        start  <= 1'b1;
        row_en <= '0;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 0; i < 30; i++) begin
            @(negedge clk);
            if (opsum_valid !== 1'b0 || busy !== 1'b0 || done !== 1'b0) begin
                err_cnt++;
                $display("ERR opsum_valid/busy/done idle cycle %0d: expected 0 0 0, %s",
                         i, $sformatf("actual %h %h %h", opsum_valid, busy, done));
            end
        end

        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/ipsum_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module ipsum_buffer import psum_pkg::*; #(
    parameter int ROW_NUM = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  layer_mode_t         layer_mode,
    input  row_cnt_t            row_en,
    // store strobe pair
    input  logic                ready_ip,
    input  logic                valid_ip,
    input  logic                clear,
    input  glb_word_t           ipsum_in,   // from glb
    input  logic                ipsum_out_f, // drain toward the reducer
    output psum_t [ROW_NUM-1:0] ipsum_out
);

    logic     store;
    row_cnt_t row_lim;
    row_cnt_t row_ptr;  // row that takes the next word
    logic     half_sel; // pw only, second word of the row
    psum_t    word_hi;
    psum_t    word_lo;

    assign store   = ready_ip && valid_ip;
    assign word_hi = ipsum_in[31:16];
    assign word_lo = ipsum_in[15:0];

    always_comb begin
        if (row_en > row_cnt_t'(ROW_NUM)) begin
            row_lim = row_cnt_t'(ROW_NUM);
        end else begin
            row_lim = row_en;
        end
    end

    // --------------------
    // row steering

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            row_ptr  <= '0;
            half_sel <= 1'b0;
        end else if (store) begin
            if (layer_mode == LAYER_DW) begin
                half_sel <= 1'b0;
                // one word per row, skip two rows
                if (row_ptr + DW_ROW_STEP >= row_lim) begin
                    row_ptr <= '0;
                end else begin
                    row_ptr <= row_ptr + DW_ROW_STEP;
                end
            end else begin
                half_sel <= ~half_sel;
                if (half_sel) begin // row full after two words
                    if (row_ptr + row_cnt_t'(1) >= row_lim) begin
                        row_ptr <= '0;
                    end else begin
                        row_ptr <= row_ptr + row_cnt_t'(1);
                    end
                end
            end
        end
    end

    // --------------------
    // per-row fifos
    // slot 3 is the oldest entry and feeds the reducer

    for (genvar r = 0; r < ROW_NUM; r++) begin : g_row
        psum_t slot [4];
        logic  row_hit;

        assign row_hit = store && (row_ptr == row_cnt_t'(r));

        always_ff @(posedge clk) begin
            if (reset || clear) begin
                slot[0] <= '0;
                slot[1] <= '0;
                slot[2] <= '0;
                slot[3] <= '0;
            end else if (row_hit) begin
                if (layer_mode == LAYER_DW) begin
                    slot[0] <= '0;      // upper slots unused in dw
                    slot[1] <= '0;
                    slot[2] <= word_hi;
                    slot[3] <= word_lo;
                end else begin
                    // newer word in front, older one pushed back
                    slot[0] <= word_hi;
                    slot[1] <= word_lo;
                    slot[2] <= slot[0];
                    slot[3] <= slot[1];
                end
            end else if (ipsum_out_f) begin
                slot[0] <= '0; // zero fill
                slot[1] <= slot[0];
                slot[2] <= slot[1];
                slot[3] <= slot[2];
            end
        end

        assign ipsum_out[r] = slot[3];
    end

endmodule

`default_nettype wire

// File: verilog/psum_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module psum_ctrl import psum_pkg::*; #(
    parameter int ROW_NUM = 32
) (
    input  logic        clk,
    input  logic        reset,
    // pass control from the host
    input  logic        start,
    input  layer_mode_t layer_mode,
    input  row_cnt_t    row_en,
    input  glb_addr_t   base_addr,
    // glb side
    input  logic        glb_rd_valid,
    output logic        glb_rd_en,
    output glb_addr_t   glb_rd_addr,
    // buffer side
    output logic        ready_ip,
    output logic        clear,
    output logic        ipsum_out_f,
    // status
    output logic        busy,
    output logic        done
);

    ctrl_state_e state;

    row_cnt_t   row_lim;    // row_en clipped to the array size
    logic [6:0] word_num;   // words needed for this pass, up to 64
    logic [6:0] word_tgt;   // word_num latched at start
    logic [6:0] rd_cnt;     // reads issued so far, including the current one
    logic [1:0] drain_cnt;

    // --------------------
    // pass sizing

    always_comb begin
        if (row_en > row_cnt_t'(ROW_NUM)) begin
            row_lim = row_cnt_t'(ROW_NUM);
        end else begin
            row_lim = row_en;
        end

        if (layer_mode == LAYER_DW) begin
            // one word per group of three rows, rounded up
            word_num = (7'(row_lim) + 7'd2) / 7'(DW_ROW_STEP);
        end else begin
            word_num = {row_lim, 1'b0}; // two words per row
        end
    end

    // --------------------
    // sequencer

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            glb_rd_addr <= '0;
            word_tgt    <= '0;
            rd_cnt      <= '0;
            drain_cnt   <= '0;
            clear       <= 1'b0;
            done        <= 1'b0;
        end else begin
            clear <= 1'b0;
            done  <= 1'b0;
            case (state)
                IDLE: begin
                    if (start && (row_lim != '0)) begin
                        state       <= LOAD;
                        clear       <= 1'b1; // wipe stale rows before the first store
                        glb_rd_addr <= base_addr;
                        word_tgt    <= word_num;
                        rd_cnt      <= 7'd1;
                    end
                end
                LOAD: begin
                    if (rd_cnt == word_tgt) begin
                        state <= WAIT_LAST; // last read is on the bus now
                    end else begin
                        rd_cnt      <= rd_cnt + 7'd1;
                        glb_rd_addr <= glb_rd_addr + glb_addr_t'(1);
                    end
                end
                WAIT_LAST: begin
                    // only the final read data can arrive here
                    if (glb_rd_valid) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    drain_cnt <= drain_cnt + 2'd1;
                    if (drain_cnt == 2'd3) begin
                        state <= IDLE;
                        done  <= 1'b1; // lines up with the last reducer beat
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign glb_rd_en   = (state == LOAD);
    assign ready_ip    = (state == LOAD) || (state == WAIT_LAST);
    assign ipsum_out_f = (state == DRAIN);
    assign busy        = (state != IDLE);

endmodule

`default_nettype wire

// File: verilog/psum_glb.sv
`timescale 1ns/1ps
`default_nettype none

module psum_glb import psum_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // host write port
    input  logic      wr_en,
    input  glb_addr_t wr_addr,
    input  glb_word_t wr_data,
    // read port toward the ipsum buffer
    input  logic      glb_rd_en,
    input  glb_addr_t glb_rd_addr,
    output glb_word_t glb_rd_data,
    output logic      glb_rd_valid
);

    localparam int DEPTH = 2 ** $bits(glb_addr_t);

    glb_word_t mem [DEPTH];

    // --------------------
    // storage

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle after the enable
    always_ff @(posedge clk) begin
        if (glb_rd_en) begin
            glb_rd_data <= mem[glb_rd_addr];
        end
    end

    // --------------------
    // read strobe toward the buffer

    always_ff @(posedge clk) begin
        if (reset) begin
            glb_rd_valid <= 1'b0;
        end else begin
            glb_rd_valid <= glb_rd_en; // follows data by construction
        end
    end

endmodule

`default_nettype wire

// File: verilog/psum_pkg.sv
`default_nettype none

package psum_pkg;

    // --------------------
    // data widths

    typedef logic signed [15:0] psum_t;     // one partial sum
    typedef logic [31:0]        glb_word_t; // hi psum in 31:16, lo psum in 15:0
    typedef logic [5:0]         glb_addr_t; // 64 words of scratchpad
    typedef logic [5:0]         row_cnt_t;  // row count or row index, 0..32
    typedef logic               layer_mode_t;

    // --------------------
    // layer modes

    localparam layer_mode_t LAYER_PW = 1'b0;
    localparam layer_mode_t LAYER_DW = 1'b1;

    localparam row_cnt_t DW_ROW_STEP = 6'd3; // dw writes every third row

    // saturation limits
    localparam psum_t PSUM_MAX = 16'sh7fff;
    localparam psum_t PSUM_MIN = 16'sh8000;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        WAIT_LAST,
        DRAIN
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: verilog/psum_reducer.sv
`timescale 1ns/1ps
`default_nettype none

module psum_reducer import psum_pkg::*; #(
    parameter int ROW_NUM = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                ipsum_out_f,
    input  psum_t [ROW_NUM-1:0] ipsum_out, // from the ipsum buffer
    input  psum_t [ROW_NUM-1:0] pe_psum,   // new psums from the pe array
    output psum_t [ROW_NUM-1:0] opsum,
    output logic                opsum_valid
);

    psum_t [ROW_NUM-1:0] sat_sum;

    // --------------------
    // per-lane saturating add

    for (genvar r = 0; r < ROW_NUM; r++) begin : g_lane
        logic signed [16:0] wide_sum;

        // sign extend both operands by one bit
        assign wide_sum = {ipsum_out[r][15], ipsum_out[r]} + {pe_psum[r][15], pe_psum[r]};

        always_comb begin
            if (wide_sum[16] != wide_sum[15]) begin
                // overflow, direction given by the true sign
                sat_sum[r] = wide_sum[16] ? PSUM_MIN : PSUM_MAX;
            end else begin
                sat_sum[r] = wide_sum[15:0];
            end
        end
    end

    // --------------------
    // output register

    always_ff @(posedge clk) begin
        if (reset) begin
            opsum       <= '0;
            opsum_valid <= 1'b0;
        end else begin
            opsum_valid <= ipsum_out_f;
            if (ipsum_out_f) begin
                opsum <= sat_sum; // hold last result between passes
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/psum_top.sv
`timescale 1ns/1ps
`default_nettype none

module psum_top import psum_pkg::*; #(
    parameter int ROW_NUM = 32
) (
    input  logic                clk,
    input  logic                reset,
    // host write port
    input  logic                wr_en,
    input  glb_addr_t           wr_addr,
    input  glb_word_t           wr_data,
    // pass control
    input  logic                start,
    input  layer_mode_t         layer_mode,
    input  row_cnt_t            row_en,
    input  glb_addr_t           base_addr,
    // pe array side
    input  psum_t [ROW_NUM-1:0] pe_psum,
    output psum_t [ROW_NUM-1:0] opsum,
    output logic                opsum_valid,
    output logic                busy,
    output logic                done
);

    logic                glb_rd_en;
    glb_addr_t           glb_rd_addr;
    glb_word_t           glb_rd_data;
    logic                glb_rd_valid;
    logic                ready_ip;
    logic                clear;
    logic                ipsum_out_f;
    psum_t [ROW_NUM-1:0] ipsum_out;

    psum_glb u_glb (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .glb_rd_en    (glb_rd_en),
        .glb_rd_addr  (glb_rd_addr),
        .glb_rd_data  (glb_rd_data),
        .glb_rd_valid (glb_rd_valid)
    );

    psum_ctrl #(.ROW_NUM(ROW_NUM)) u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .layer_mode   (layer_mode),
        .row_en       (row_en),
        .base_addr    (base_addr),
        .glb_rd_valid (glb_rd_valid),
        .glb_rd_en    (glb_rd_en),
        .glb_rd_addr  (glb_rd_addr),
        .ready_ip     (ready_ip),
        .clear        (clear),
        .ipsum_out_f  (ipsum_out_f),
        .busy         (busy),
        .done         (done)
    );

    ipsum_buffer #(.ROW_NUM(ROW_NUM)) u_buffer (
        .clk         (clk),
        .reset       (reset),
        .layer_mode  (layer_mode),
        .row_en      (row_en),
        .ready_ip    (ready_ip),
        .valid_ip    (glb_rd_valid),
        .clear       (clear),
        .ipsum_in    (glb_rd_data),
        .ipsum_out_f (ipsum_out_f),
        .ipsum_out   (ipsum_out)
    );

    psum_reducer #(.ROW_NUM(ROW_NUM)) u_reducer (
        .clk         (clk),
        .reset       (reset),
        .ipsum_out_f (ipsum_out_f),
        .ipsum_out   (ipsum_out),
        .pe_psum     (pe_psum),
        .opsum       (opsum),
        .opsum_valid (opsum_valid)
    );

endmodule

`default_nettype wire

// File: vlog.f
verilog/psum_pkg.sv
verilog/psum_glb.sv
verilog/psum_ctrl.sv
verilog/ipsum_buffer.sv
verilog/psum_reducer.sv
verilog/psum_top.sv
tb/psum_props.sv
tb/tb_psum_top.sv
